//--- hw/cacheSystem.sv
//##########################################################################
// top level that puts the data cache in front of the main memory
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cacheSystem (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              dmemREN,
	input  logic              dmemWEN,
	input  logic [31:0]       dmemAddr,
	input  cpuTypesPkg::wordT dmemStore,
	input  logic              halt,
	output cpuTypesPkg::wordT dmemLoad,
	output logic              dHit,
	output logic              flushed
);

	// internal memory bus
	logic              dREN, dWEN, dWait;
	logic [31:0]       dAddr;
	cpuTypesPkg::wordT dStore, dLoad;

	dataCache cache (
		.CLK, .nRST,
		.dmemREN, .dmemWEN, .dmemAddr, .dmemStore, .halt,
		.dmemLoad, .dHit, .flushed,
		.dREN, .dWEN, .dAddr, .dStore, .dLoad, .dWait
	);

	mainMemory mem (
		.CLK, .nRST,
		.dREN, .dWEN, .dAddr, .dStore,
		.dLoad, .dWait
	);

endmodule

`default_nettype wire

//--- hw/cpuTypesPkg.sv
//##########################################################################
// CPU side word and address types with the cache geometry, referenced by
// the cache, the memory and the testbench through scoped names
//##########################################################################
`default_nettype none

package cpuTypesPkg;

	// one datapath word
	typedef logic [31:0] wordT;

	// address fields of a byte address
	typedef logic [25:0] tagT;   // bits 31 to 6
	typedef logic [2:0]  indexT; // bits 5 to 3

	// bit 2 picks the word inside a block
	// bits 1 and 0 are the byte offset, never looked at

	// cache geometry
	localparam int SETS        = 8;
	localparam int WAYS        = 2;
	localparam int BLOCK_WORDS = 2;

endpackage

`default_nettype wire

//--- hw/dataCache.sv
//##########################################################################
// two way set associative write-back data cache with LRU, write-allocate
// and a flush on halt that writes every dirty block back to memory
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module dataCache (
	input  logic              CLK,
	input  logic              nRST,
	// datapath side
	input  logic              dmemREN,
	input  logic              dmemWEN,
	input  logic [31:0]       dmemAddr,
	input  cpuTypesPkg::wordT dmemStore,
	input  logic              halt,
	output cpuTypesPkg::wordT dmemLoad,
	output logic              dHit,
	output logic              flushed,
	// memory side
	output logic              dREN,
	output logic              dWEN,
	output logic [31:0]       dAddr,
	output cpuTypesPkg::wordT dStore,
	input  cpuTypesPkg::wordT dLoad,
	input  logic              dWait
);

	typedef enum logic [3:0] {
		IDLE, SELECT, WRITEBACK1, WRITEBACK2, FETCH1, FETCH2, HIT, FLUSH, FLUSHED
	} cacheStateT;

	cacheStateT state, nextState;

	// block storage
	cpuTypesPkg::tagT  tags [cpuTypesPkg::SETS][cpuTypesPkg::WAYS];
	cpuTypesPkg::wordT blockData [cpuTypesPkg::SETS][cpuTypesPkg::WAYS]
		[cpuTypesPkg::BLOCK_WORDS];
	logic [cpuTypesPkg::SETS-1:0][cpuTypesPkg::WAYS-1:0] valid, dirty;
	logic [cpuTypesPkg::SETS-1:0] lru; // way to evict next
	logic curWay;                      // latched in SELECT

	// request address fields
	cpuTypesPkg::tagT   reqTag;
	cpuTypesPkg::indexT index;
	logic               offset;

	logic hit0, hit1, hit;
	logic selWay;
	logic victimDirty;

	// flush walker
	cpuTypesPkg::indexT flushSet;
	logic flushWay, flushWord;
	logic flushDirty, flushLast, flushStep;

	assign reqTag = cpuTypesPkg::tagT'(dmemAddr[31:6]);
	assign index  = cpuTypesPkg::indexT'(dmemAddr[5:3]);
	assign offset = dmemAddr[2];

	assign hit0 = valid[index][0] && (tags[index][0] == reqTag);
	assign hit1 = valid[index][1] && (tags[index][1] == reqTag);
	assign hit  = hit0 || hit1;
	assign selWay = hit ? hit1 : lru[index]; // victim is the LRU way on a miss
	assign victimDirty = valid[index][lru[index]] && dirty[index][lru[index]];

	assign flushDirty = valid[flushSet][flushWay] && dirty[flushSet][flushWay];
	assign flushLast  = (flushSet == cpuTypesPkg::indexT'(cpuTypesPkg::SETS - 1)) && flushWay;
	assign flushStep  = !flushDirty || (flushWord && !dWait); // block done this cycle

	assign dmemLoad = blockData[index][curWay][offset];
	assign dHit     = (state == HIT);
	assign flushed  = (state == FLUSHED);

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (dmemREN || dmemWEN)
					nextState = SELECT;
				else if (halt)
					nextState = FLUSH;
			end
			SELECT: begin
				if (hit)
					nextState = HIT;
				else if (victimDirty)
					nextState = WRITEBACK1;
				else
					nextState = FETCH1;
			end
			WRITEBACK1: if (!dWait) nextState = WRITEBACK2;
			WRITEBACK2: if (!dWait) nextState = FETCH1;
			FETCH1:     if (!dWait) nextState = FETCH2;
			FETCH2:     if (!dWait) nextState = HIT;
			HIT:        nextState = IDLE;
			FLUSH:      if (flushStep && flushLast) nextState = FLUSHED;
			FLUSHED:    nextState = FLUSHED; // held until reset
			default:    nextState = IDLE;
		endcase
	end

	// memory bus drive
	always_comb begin
		dREN   = (state == FETCH1) || (state == FETCH2);
		dWEN   = (state == WRITEBACK1) || (state == WRITEBACK2)
			|| ((state == FLUSH) && flushDirty);
		dAddr  = {reqTag, index, offset, 2'b00};
		dStore = '0;
		case (state)
			WRITEBACK1: begin
				dAddr  = {tags[index][curWay], index, 1'b0, 2'b00}; // victim's own tag
				dStore = blockData[index][curWay][0];
			end
			WRITEBACK2: begin
				dAddr  = {tags[index][curWay], index, 1'b1, 2'b00};
				dStore = blockData[index][curWay][1];
			end
			FETCH1: dAddr = {reqTag, index, 1'b0, 2'b00};
			FETCH2: dAddr = {reqTag, index, 1'b1, 2'b00};
			FLUSH: begin
				dAddr  = {tags[flushSet][flushWay], flushSet, flushWord, 2'b00};
				dStore = blockData[flushSet][flushWay][flushWord];
			end
			default: ;
		endcase
	end

	// control state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= IDLE;
			curWay    <= 1'b0;
			valid     <= '0;
			dirty     <= '0;
			lru       <= '0;
			flushSet  <= '0;
			flushWay  <= 1'b0;
			flushWord <= 1'b0;
		end else begin
			state <= nextState;
			case (state)
				SELECT: curWay <= selWay;
				FETCH2: begin
					if (!dWait) begin
						valid[index][curWay] <= 1'b1; // fresh block is clean
						dirty[index][curWay] <= 1'b0;
					end
				end
				HIT: begin
					lru[index] <= !curWay;
					if (dmemWEN)
						dirty[index][curWay] <= 1'b1;
				end
				FLUSH: begin
					if (flushStep) begin
						valid[flushSet][flushWay] <= 1'b0;
						dirty[flushSet][flushWay] <= 1'b0;
						flushWord <= 1'b0;
						flushWay  <= !flushWay;
						if (flushWay)
							flushSet <= flushSet + 1'b1;
					end else if (!dWait) begin
						flushWord <= 1'b1; // first word written
					end
				end
				default: ;
			endcase
		end
	end

	// block payload
	always_ff @(posedge CLK) begin
		if (state == FETCH1 && !dWait)
			blockData[index][curWay][0] <= dLoad;
		if (state == FETCH2 && !dWait) begin
			blockData[index][curWay][1] <= dLoad;
			tags[index][curWay] <= reqTag;
		end
		if (state == HIT && dmemWEN)
			blockData[index][curWay][offset] <= dmemStore;
	end

	// the requester must still hold its request when the hit comes back
	hitHasRequest: assert property (@(posedge CLK) disable iff (!nRST)
		dHit |-> (dmemREN || dmemWEN))
		else $error("dataCache: dHit without a pending request");

	// address and direction stay put from SELECT until dHit
	requestHeld: assert property (@(posedge CLK) disable iff (!nRST)
		(state inside {SELECT, WRITEBACK1, WRITEBACK2, FETCH1, FETCH2})
		|=> ($stable(dmemAddr) && $stable(dmemREN) && $stable(dmemWEN)))
		else $error("dataCache: request changed before dHit");

endmodule

`default_nettype wire

//--- hw/mainMemory.sv
//##########################################################################
// word RAM that stalls each access for a fixed number of cycles with dWait
// and completes it on the first edge where dWait is low
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module mainMemory (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              dREN,
	input  logic              dWEN,
	input  logic [31:0]       dAddr,
	input  cpuTypesPkg::wordT dStore,
	output cpuTypesPkg::wordT dLoad,
	output logic              dWait
);

	localparam int CNT_W = $clog2(memBusPkg::MEM_LATENCY + 1);

	cpuTypesPkg::wordT ram [memBusPkg::MEM_WORDS] = '{default: '0};

	memBusPkg::memIndexT memIdx;
	logic             access, newAccess;
	logic             active;       // an access is being counted
	logic [CNT_W-1:0] waitCnt;
	logic [31:0]      lastAddr;
	logic             lastWen;

	assign memIdx = memBusPkg::memIndexT'(dAddr[11:2]);
	assign access = dREN || dWEN;
	// fresh count on a new access or a change of address or direction
	assign newAccess = access && (!active || (dAddr != lastAddr) || (dWEN != lastWen));
	assign dWait = access && (newAccess || (waitCnt != '0));
	assign dLoad = ram[memIdx];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			active  <= 1'b0;
			waitCnt <= '0;
		end else if (!access) begin
			active <= 1'b0;
		end else if (newAccess) begin
			active  <= 1'b1;
			waitCnt <= CNT_W'(memBusPkg::MEM_LATENCY - 1); // first wait cycle is this one
		end else if (waitCnt != '0) begin
			waitCnt <= waitCnt - 1'b1;
		end else begin
			active <= 1'b0; // completed, next access counts again
		end
	end

	always_ff @(posedge CLK) begin
		if (newAccess) begin
			lastAddr <= dAddr;
			lastWen  <= dWEN;
		end
	end

	always_ff @(posedge CLK) begin
		if (dWEN && !dWait)
			ram[memIdx] <= dStore;
	end

	addrStable: assert property (@(posedge CLK) disable iff (!nRST)
		dWait |=> $stable(dAddr))
		else $error("mainMemory: dAddr changed during a wait");

	// a held access waits exactly the fixed count
	fixedLatency: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(dWait) |-> dWait [*memBusPkg::MEM_LATENCY] ##1 !dWait)
		else $error("mainMemory: wait length differs from MEM_LATENCY");

endmodule

`default_nettype wire

//--- hw/memBusPkg.sv
//##########################################################################
// memory side types, RAM depth and the fixed wait count of every access
//##########################################################################
`default_nettype none

package memBusPkg;

	// word index into the RAM, byte address bits 11 to 2
	typedef logic [9:0] memIndexT;

	localparam int MEM_WORDS   = 1024; // 4 KB of words
	localparam int MEM_LATENCY = 3;    // wait cycles before an access completes

endpackage

`default_nettype wire

//--- list.f
+incdir+test
hw/cpuTypesPkg.sv
hw/memBusPkg.sv
hw/mainMemory.sv
hw/dataCache.sv
hw/cacheSystem.sv
test/cacheSystemTb.sv

//--- test/tbTasks.svh
//##########################################################################
// request, halt and random number helpers, included inside the testbench
// module so they drive the DUT inputs and the shadow model directly
//##########################################################################
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// single read or write, held through the edge that closes the HIT cycle
task automatic cacheAccess(input logic isWrite, input logic [31:0] addr,
	input cpuTypesPkg::wordT data, output int cycles);
	int idx;
	idx = int'(addr[11:2]);
	cycles = 0;
	@(negedge CLK);
	dmemAddr  = addr;
	dmemStore = data;
	dmemREN   = !isWrite;
	dmemWEN   = isWrite;
	if (!isWrite)
		expWord = shadow[idx]; // what the read must return
	while (!dHit && cycles < REQ_TIMEOUT) begin
		@(negedge CLK);
		cycles++;
	end
	if (!dHit) begin
		$display("timeout: no dHit for the %s of address %h within %0d cycles",
			isWrite ? "write" : "read", addr, cycles);
		errCount++;
		timedOut = 1'b1;
	end else begin
		@(negedge CLK); // HIT updates data and LRU on this edge
		if (isWrite) begin
			shadow[idx]  = data;
			written[idx] = 1'b1;
		end
	end
	dmemREN = 1'b0;
	dmemWEN = 1'b0;
endtask

task automatic readWord(input logic [31:0] addr, output int cycles);
	cacheAccess(1'b0, addr, '0, cycles);
endtask

task automatic writeWord(input logic [31:0] addr, input cpuTypesPkg::wordT data,
	output int cycles);
	cacheAccess(1'b1, addr, data, cycles);
endtask

// raise halt and wait for the flush to finish, halt stays high
task automatic flushCache(output int cycles);
	cycles = 0;
	@(negedge CLK);
	halt = 1'b1;
	while (!flushed && cycles < FLUSH_TIMEOUT) begin
		@(negedge CLK);
		cycles++;
	end
	if (!flushed) begin
		$display("timeout: flushed did not rise within %0d cycles of halt", cycles);
		errCount++;
		timedOut = 1'b1;
	end
endtask

`endif

//--- test/cacheSystemTb.sv
//##########################################################################
// testbench for the cache system, runs directed and random traffic against
// a shadow copy of memory and checks the DUT with assertions
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cacheSystemTb;

	localparam int REQ_TIMEOUT   = 200;  // cycles, a dirty miss needs about 20
	localparam int FLUSH_TIMEOUT = 2000;
	localparam int RANDOM_OPS    = 200;

	logic              CLK = 1'b0;
	logic              nRST;
	logic              dmemREN, dmemWEN, halt;
	logic [31:0]       dmemAddr;
	cpuTypesPkg::wordT dmemStore, dmemLoad;
	logic              dHit, flushed;

	// expected memory, indexed like the RAM
	cpuTypesPkg::wordT shadow [memBusPkg::MEM_WORDS];
	bit                written [memBusPkg::MEM_WORDS];
	cpuTypesPkg::wordT expWord; // expected load of the pending read
	logic [31:0]       rngState;
	logic              timedOut;
	int                errCount, errBefore, testsPassed, testsFailed;

	always #4 CLK = ~CLK;

	cacheSystem DUT (
		.CLK, .nRST,
		.dmemREN, .dmemWEN, .dmemAddr, .dmemStore, .halt,
		.dmemLoad, .dHit, .flushed
	);

	`include "tbTasks.svh"

	readMatches: assert property (@(posedge CLK) disable iff (!nRST)
		(dHit && dmemREN) |-> (dmemLoad == expWord))
		else begin
			errCount++;
			$display("Error at %0t: dmemLoad = %h, expected %h",
				$time, $sampled(dmemLoad), $sampled(expWord));
		end

	hitIsPulse: assert property (@(posedge CLK) disable iff (!nRST)
		dHit |=> !dHit)
		else begin
			errCount++;
			$display("Error at %0t: dHit stayed high for more than one cycle", $time);
		end

	flushedHolds: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed)
		else begin
			errCount++;
			$display("Error at %0t: flushed fell before reset", $time);
		end

	// fixed length reset, memory contents survive it
	task automatic applyReset();
		nRST      = 1'b0;
		halt      = 1'b0;
		dmemREN   = 1'b0;
		dmemWEN   = 1'b0;
		dmemAddr  = '0;
		dmemStore = '0;
		repeat (5) @(negedge CLK);
		nRST = 1'b1;
	endtask

	task automatic reportTest(input string name);
		if (errCount == errBefore) begin
			testsPassed++;
			$display("test %-10s ok", name);
		end else begin
			testsFailed++;
			$display("test %-10s %0d errors", name, errCount - errBefore);
		end
		errBefore = errCount;
	endtask

	task automatic checkLatency(input int cycles, input int expected);
		assert (cycles == expected) else begin
			errCount++;
			$display("Error at %0t: dHit latency = %0d, expected %0d", $time, cycles, expected);
		end
	endtask

	initial begin
		int lat;
		logic [31:0] addr;
		cpuTypesPkg::wordT data;
		shadow    = '{default: '0};
		written   = '{default: 1'b0};
		expWord   = '0;
		rngState  = 32'ha81caf93;
		timedOut  = 1'b0;
		errCount  = 0;
		errBefore = 0;
		testsPassed = 0;
		testsFailed = 0;
		applyReset();

		// outputs quiet, memory reads as zero
		assert (!dHit && !flushed) else begin
			errCount++;
			$display("Error at %0t: dHit = %b flushed = %b, expected 0 0", $time, dHit, flushed);
		end
		readWord(32'h000, lat);
		if (!timedOut) readWord(32'h7fc, lat);
		if (!timedOut) readWord(32'hff8, lat);
		reportTest("reset");

		if (!timedOut) begin
			writeWord(32'h100, 32'hcafe_0100, lat);
			if (!timedOut) readWord(32'h100, lat);
			if (!timedOut) checkLatency(lat, 2); // same block, must hit
			reportTest("readHit");
		end

		// set 2, three tags force a dirty eviction
		if (!timedOut) begin
			writeWord(32'h210, 32'h1111_0210, lat);
			if (!timedOut) writeWord(32'h250, 32'h2222_0250, lat);
			if (!timedOut) writeWord(32'h290, 32'h3333_0290, lat);
			if (!timedOut) readWord(32'h210, lat);
			if (!timedOut) readWord(32'h250, lat);
			if (!timedOut) readWord(32'h290, lat);
			reportTest("eviction");
		end

		// set 5, A B A then C must push out B
		if (!timedOut) begin
			writeWord(32'h428, 32'haaaa_0428, lat);
			if (!timedOut) writeWord(32'h468, 32'hbbbb_0468, lat);
			if (!timedOut) readWord(32'h428, lat);
			if (!timedOut) readWord(32'h4a8, lat);
			if (!timedOut) readWord(32'h428, lat);
			if (!timedOut) checkLatency(lat, 2);
			if (!timedOut) readWord(32'h468, lat);
			if (!timedOut) assert (lat > 2) else begin
				errCount++;
				$display("Error at %0t: dHit latency = %0d, expected more than 2", $time, lat);
			end
			reportTest("lru");
		end

		if (!timedOut) begin
			for (int i = 0; i < RANDOM_OPS && !timedOut; i++) begin
				rngState = xorshift(rngState);
				addr = {20'h0, rngState[11:2], 2'b00}; // 4 KB window
				if (rngState[12]) begin
					rngState = xorshift(rngState);
					data = rngState;
					writeWord(addr, data, lat);
				end else begin
					readWord(addr, lat);
				end
			end
			reportTest("random");
		end

		// flush, then a reset empties the cache but keeps the RAM
		if (!timedOut) begin
			flushCache(lat);
			if (!timedOut) begin
				applyReset();
				for (int i = 0; i < memBusPkg::MEM_WORDS && !timedOut; i++)
					if (written[i])
						readWord({20'h0, 10'(i), 2'b00}, lat);
			end
			reportTest("flush");
		end

		$display("%0d tests passed, %0d tests failed", testsPassed, testsFailed);
		if (errCount == 0 && !timedOut) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
